//--- common/sram_wrap_pkg.sv
package sram_wrap_pkg;

  // ----------------------------------------
  // Memory geometry
  // ----------------------------------------
  localparam int LANE_W     = 32;                   // One lane word
  localparam int NUM_LANES  = 4;                    // Lanes side by side
  localparam int DATA_W     = LANE_W * NUM_LANES;   // Full bus width
  localparam int LANE_DEPTH = 256;                  // Rows per lane
  localparam int ROW_W      = $clog2(LANE_DEPTH);   // Row index width
  localparam int ADDR_W     = ROW_W + 4;            // Used byte address bits

  // Address bits 3:2 pick the lane, ADDR_W-1:4 pick the row
  typedef logic [1:0]       lane_sel_t;
  typedef logic [ROW_W-1:0] row_t;

  // ----------------------------------------
  // Transfer size
  // ----------------------------------------
  // Anything other than a line is handled as a word
  typedef enum logic [2:0] {
    HSIZE_WORD = 3'b010,                            // 32 bit
    HSIZE_LINE = 3'b100                             // 128 bit, all lanes
  } hsize_e;

  // ----------------------------------------
  // Port controller states
  // ----------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE,                                        // No transfer pending
    ST_READ,                                        // Read data phase
    ST_WRITE,                                       // Write data phase, commit
    ST_WAIT                                         // Stall for read after write
  } port_state_e;

endpackage

//--- sram_wrap/dp_sram_lane.sv
`timescale 1ns/1ps

module dp_sram_lane (
  input  logic                             hclk,
  input  logic                             en_a,      // Port A access
  input  logic                             we_a,      // Port A write
  input  sram_wrap_pkg::row_t              row_a,
  input  logic [sram_wrap_pkg::LANE_W-1:0] wdata_a,
  input  logic                             en_b,      // Port B access
  input  logic                             we_b,      // Port B write
  input  sram_wrap_pkg::row_t              row_b,
  input  logic [sram_wrap_pkg::LANE_W-1:0] wdata_b,
  output logic [sram_wrap_pkg::LANE_W-1:0] rdata_a,
  output logic [sram_wrap_pkg::LANE_W-1:0] rdata_b
);

  import sram_wrap_pkg::*;

  logic [LANE_W-1:0] mem [LANE_DEPTH];

  // Same-row writes from both ports in one cycle are undefined
  always_ff @(posedge hclk) begin
    if (en_a && we_a) begin
      mem[row_a] <= wdata_a;
    end
    if (en_b && we_b) begin
      mem[row_b] <= wdata_b;
    end
  end

  // ----------------------------------------
  // Registered read ports
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (en_a && !we_a) begin
      rdata_a <= mem[row_a];                          // Holds otherwise
    end
  end

  always_ff @(posedge hclk) begin
    if (en_b && !we_b) begin
      rdata_b <= mem[row_b];
    end
  end

endmodule

//--- sram_wrap/ahb_port_ctrl.sv
`timescale 1ns/1ps

module ahb_port_ctrl (
  input  logic                                hclk,
  input  logic                                hresetn,
  input  logic                                hsel,        // Non-sequential transfer
  input  logic [31:0]                         haddr,
  input  sram_wrap_pkg::hsize_e               hsize,
  input  logic                                hwrite,
  input  logic [sram_wrap_pkg::DATA_W-1:0]    hwdata,
  output logic [sram_wrap_pkg::DATA_W-1:0]    hrdata,
  output logic                                hready,      // Low only in ST_WAIT
  output logic [sram_wrap_pkg::NUM_LANES-1:0] lane_en,     // One bit per lane
  output logic                                lane_we,     // Shared by all lanes
  output sram_wrap_pkg::row_t                 lane_row,
  output logic [sram_wrap_pkg::DATA_W-1:0]    lane_wdata,  // Lane i at bits 32i+31:32i
  input  logic [sram_wrap_pkg::DATA_W-1:0]    lane_rdata
);

  import sram_wrap_pkg::*;

  port_state_e          state;
  port_state_e          state_nxt;
  logic                 accept;        // Address phase taken this cycle
  logic [ADDR_W-1:0]    addr_q;        // Write or stalled read address
  hsize_e               size_q;
  logic                 lane_act;      // Lanes accessed this cycle
  logic [ADDR_W-1:0]    sel_addr;
  hsize_e               sel_size;
  lane_sel_t            sel_lane;
  logic                 sel_line;
  logic [NUM_LANES-1:0] rd_lanes_q;    // Lanes read for the data phase
  logic                 rd_line_q;
  logic [LANE_W-1:0]    word_rdata;

  assign accept = hsel & hready;

  // ----------------------------------------
  // Transfer FSM
  // ----------------------------------------
  always_comb begin
    state_nxt = ST_IDLE;
    case (state)
      ST_IDLE, ST_READ: begin
        if (accept) begin
          state_nxt = hwrite ? ST_WRITE : ST_READ;
        end
      end
      ST_WRITE: begin
        // A read behind a write must wait for the lanes
        if (accept) begin
          state_nxt = hwrite ? ST_WRITE : ST_WAIT;
        end
      end
      ST_WAIT: begin
        state_nxt = ST_IDLE;          // Stalled read issued now
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state  <= ST_IDLE;
      hready <= 1'b1;
    end else begin
      state  <= state_nxt;
      hready <= (state_nxt != ST_WAIT);
    end
  end

  // Address and size for the cycle after acceptance
  always_ff @(posedge hclk) begin
    if (state_nxt == ST_WRITE || state_nxt == ST_WAIT) begin
      addr_q <= haddr[ADDR_W-1:0];
      size_q <= hsize;
    end
  end

  // ----------------------------------------
  // Lane access
  // ----------------------------------------
  always_comb begin
    lane_act = 1'b0;
    lane_we  = 1'b0;
    sel_addr = addr_q;
    sel_size = size_q;
    case (state)
      ST_IDLE, ST_READ: begin
        lane_act = accept & ~hwrite;  // Read straight from the bus
        sel_addr = haddr[ADDR_W-1:0];
        sel_size = hsize;
      end
      ST_WRITE: begin
        lane_act = 1'b1;
        lane_we  = 1'b1;
      end
      ST_WAIT: begin
        lane_act = 1'b1;
      end
      default: begin
        lane_act = 1'b0;
      end
    endcase
  end

  assign sel_lane = sel_addr[3:2];
  assign sel_line = (sel_size == HSIZE_LINE);
  assign lane_row = sel_addr[ADDR_W-1:4];

  always_comb begin
    lane_en = '0;
    if (lane_act) begin
      if (sel_line) begin
        lane_en = '1;
      end else begin
        lane_en[sel_lane] = 1'b1;
      end
    end
  end

  // Word writes put the low word on every lane, lane_en picks one
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (size_q == HSIZE_LINE) begin
        lane_wdata[i*LANE_W +: LANE_W] = hwdata[i*LANE_W +: LANE_W];
      end else begin
        lane_wdata[i*LANE_W +: LANE_W] = hwdata[LANE_W-1:0];
      end
    end
  end

  // ----------------------------------------
  // Read data phase
  // ----------------------------------------
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      rd_lanes_q <= '0;
      rd_line_q  <= 1'b0;
    end else begin
      rd_lanes_q <= lane_we ? '0 : lane_en;
      rd_line_q  <= lane_act & ~lane_we & sel_line;
    end
  end

  always_comb begin
    word_rdata = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      word_rdata = word_rdata | ({LANE_W{rd_lanes_q[i]}} & lane_rdata[i*LANE_W +: LANE_W]);
    end
  end

  // Word reads return zero above bit 31
  assign hrdata = rd_line_q ? lane_rdata : {{(DATA_W-LANE_W){1'b0}}, word_rdata};

endmodule

//--- sram_wrap/sram_wrap_dp.sv
`timescale 1ns/1ps

module sram_wrap_dp (
  input  logic                             hclk,
  input  logic                             hresetn,
  // Port A
  input  logic                             hsel_a,
  input  logic [31:0]                      haddr_a,
  input  sram_wrap_pkg::hsize_e            hsize_a,
  input  logic                             hwrite_a,
  input  logic [sram_wrap_pkg::DATA_W-1:0] hwdata_a,
  output logic [sram_wrap_pkg::DATA_W-1:0] hrdata_a,
  output logic                             hready_a,
  // Port B
  input  logic                             hsel_b,
  input  logic [31:0]                      haddr_b,
  input  sram_wrap_pkg::hsize_e            hsize_b,
  input  logic                             hwrite_b,
  input  logic [sram_wrap_pkg::DATA_W-1:0] hwdata_b,
  output logic [sram_wrap_pkg::DATA_W-1:0] hrdata_b,
  output logic                             hready_b
);

  import sram_wrap_pkg::*;

  logic [NUM_LANES-1:0] lane_en_a;
  logic                 lane_we_a;
  row_t                 lane_row_a;
  logic [DATA_W-1:0]    lane_wdata_a;
  logic [DATA_W-1:0]    lane_rdata_a;    // Lane A sides, packed

  logic [NUM_LANES-1:0] lane_en_b;
  logic                 lane_we_b;
  row_t                 lane_row_b;
  logic [DATA_W-1:0]    lane_wdata_b;
  logic [DATA_W-1:0]    lane_rdata_b;    // Lane B sides, packed

  // ----------------------------------------
  // Port controllers
  // ----------------------------------------
  ahb_port_ctrl u_port_a (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .hsel       (hsel_a),
    .haddr      (haddr_a),
    .hsize      (hsize_a),
    .hwrite     (hwrite_a),
    .hwdata     (hwdata_a),
    .hrdata     (hrdata_a),
    .hready     (hready_a),
    .lane_en    (lane_en_a),
    .lane_we    (lane_we_a),
    .lane_row   (lane_row_a),
    .lane_wdata (lane_wdata_a),
    .lane_rdata (lane_rdata_a)
  );

  ahb_port_ctrl u_port_b (
    .hclk       (hclk),
    .hresetn    (hresetn),
    .hsel       (hsel_b),
    .haddr      (haddr_b),
    .hsize      (hsize_b),
    .hwrite     (hwrite_b),
    .hwdata     (hwdata_b),
    .hrdata     (hrdata_b),
    .hready     (hready_b),
    .lane_en    (lane_en_b),
    .lane_we    (lane_we_b),
    .lane_row   (lane_row_b),
    .lane_wdata (lane_wdata_b),
    .lane_rdata (lane_rdata_b)
  );

  // ----------------------------------------
  // Memory lanes
  // ----------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    dp_sram_lane u_lane (
      .hclk    (hclk),
      .en_a    (lane_en_a[i]),
      .we_a    (lane_we_a),
      .row_a   (lane_row_a),
      .wdata_a (lane_wdata_a[i*LANE_W +: LANE_W]),
      .en_b    (lane_en_b[i]),
      .we_b    (lane_we_b),
      .row_b   (lane_row_b),
      .wdata_b (lane_wdata_b[i*LANE_W +: LANE_W]),
      .rdata_a (lane_rdata_a[i*LANE_W +: LANE_W]),
      .rdata_b (lane_rdata_b[i*LANE_W +: LANE_W])
    );
  end

endmodule

//--- bench/sram_wrap_checker.sv
`timescale 1ns/1ps

module sram_wrap_checker (
  input logic hclk,
  input logic hresetn,
  input logic hready_a,
  input logic hready_b
);

  // ----------------------------------------
  // Wait state length
  // ----------------------------------------
  // Only a read right behind a write stalls, and for one cycle
  a_one_stall_a: assert property (@(posedge hclk) disable iff (!hresetn)
    !hready_a |=> hready_a)
    else $error("hready_a low for two cycles in a row");

  a_one_stall_b: assert property (@(posedge hclk) disable iff (!hresetn)
    !hready_b |=> hready_b)
    else $error("hready_b low for two cycles in a row");

  // ----------------------------------------
  // Reset exit
  // ----------------------------------------
  a_ready_at_start_a: assert property (@(posedge hclk)
    $rose(hresetn) |-> hready_a)                                // First cycle out of reset
    else $error("hready_a low in the first cycle after reset");

  a_ready_at_start_b: assert property (@(posedge hclk)
    $rose(hresetn) |-> hready_b)
    else $error("hready_b low in the first cycle after reset");

endmodule

bind sram_wrap_dp sram_wrap_checker u_checker (
  .hclk     (hclk),
  .hresetn  (hresetn),
  .hready_a (hready_a),
  .hready_b (hready_b)
);

//--- bench/tb_sram_wrap.sv
`timescale 1ns/1ps

module tb_sram_wrap;

  import sram_wrap_pkg::*;

  localparam int          WAIT_LIMIT = 8;                       // hready polls per wait
  localparam logic [31:0] ADDR_MASK  = (32'd1 << ADDR_W) - 32'd1;
  localparam logic [31:0] WORD_MASK  = ADDR_MASK & ~32'd3;
  localparam logic [31:0] LINE_MASK  = ADDR_MASK & ~32'd15;
  localparam logic [31:0] TOP_ROW    = 32'd1 << (ADDR_W - 1);   // Splits rows between ports
  localparam bit          PORT_A     = 1'b0;
  localparam bit          PORT_B     = 1'b1;

  logic              hclk;
  logic              hresetn;
  logic              hsel_a;
  logic [31:0]       haddr_a;
  hsize_e            hsize_a;
  logic              hwrite_a;
  logic [DATA_W-1:0] hwdata_a;
  logic [DATA_W-1:0] hrdata_a;
  logic              hready_a;
  logic              hsel_b;
  logic [31:0]       haddr_b;
  hsize_e            hsize_b;
  logic              hwrite_b;
  logic [DATA_W-1:0] hwdata_b;
  logic [DATA_W-1:0] hrdata_b;
  logic              hready_b;

  logic [LANE_W-1:0] ref_mem [NUM_LANES][LANE_DEPTH];           // Expected memory contents
  logic [31:0]       rng_state = 32'h6478_9c53;

  logic [DATA_W-1:0] data_exp_q [$];
  logic [DATA_W-1:0] data_act_q [$];
  string             data_name_q [$];
  logic              rdy_exp_q [$];
  logic              rdy_act_q [$];
  string             rdy_name_q [$];
  int                data_errors  = 0;
  int                ready_errors = 0;
  int                wait_errors  = 0;

  initial hclk = 1'b0;
  always #10 hclk = ~hclk;

  sram_wrap_dp u_dut (
    .hclk     (hclk),
    .hresetn  (hresetn),
    .hsel_a   (hsel_a),
    .haddr_a  (haddr_a),
    .hsize_a  (hsize_a),
    .hwrite_a (hwrite_a),
    .hwdata_a (hwdata_a),
    .hrdata_a (hrdata_a),
    .hready_a (hready_a),
    .hsel_b   (hsel_b),
    .haddr_b  (haddr_b),
    .hsize_b  (hsize_b),
    .hwrite_b (hwrite_b),
    .hwdata_b (hwdata_b),
    .hrdata_b (hrdata_b),
    .hready_b (hready_b)
  );

  // ----------------------------------------
  // Stimulus and reference model
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [DATA_W-1:0] rand_line();
    logic [DATA_W-1:0] d;
    d = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      d[i*LANE_W +: LANE_W] = next_rand();
    end
    return d;
  endfunction

  // Row and lane both show up in the word
  function automatic logic [LANE_W-1:0] fill_word(row_t row, int lane);
    return {4'ha, 4'(lane), row, ~row, 8'h5c};
  endfunction

  function automatic void ref_write(logic [31:0] addr, hsize_e size, logic [DATA_W-1:0] data);
    row_t      row;
    lane_sel_t lane;
    row  = addr[ADDR_W-1:4];
    lane = addr[3:2];
    if (size == HSIZE_LINE) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        ref_mem[i][row] = data[i*LANE_W +: LANE_W];
      end
    end else begin
      ref_mem[lane][row] = data[LANE_W-1:0];                    // Upper hwdata ignored
    end
  endfunction

  function automatic logic [DATA_W-1:0] ref_read(logic [31:0] addr, hsize_e size);
    logic [DATA_W-1:0] d;
    row_t              row;
    lane_sel_t         lane;
    row  = addr[ADDR_W-1:4];
    lane = addr[3:2];
    d    = '0;
    if (size == HSIZE_LINE) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        d[i*LANE_W +: LANE_W] = ref_mem[i][row];
      end
    end else begin
      d[LANE_W-1:0] = ref_mem[lane][row];
    end
    return d;
  endfunction

  // ----------------------------------------
  // Result checks
  // ----------------------------------------
  task automatic check_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h actual %h", name, exp, act);
      data_errors++;
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b actual %b", name, exp, act);
      ready_errors++;
    end
  endtask

  function automatic void push_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    data_name_q.push_back(name);
    data_exp_q.push_back(exp);
    data_act_q.push_back(act);
  endfunction

  function automatic void push_ready(string name, logic exp, logic act);
    rdy_name_q.push_back(name);
    rdy_exp_q.push_back(exp);
    rdy_act_q.push_back(act);
  endfunction

  // Samples taken at falling edges are compared here
  always @(posedge hclk) begin
    while (data_act_q.size() > 0) begin
      check_data(data_name_q.pop_front(), data_exp_q.pop_front(), data_act_q.pop_front());
    end
    while (rdy_act_q.size() > 0) begin
      check_ready(rdy_name_q.pop_front(), rdy_exp_q.pop_front(), rdy_act_q.pop_front());
    end
  end

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  task automatic drive_addr(bit port, logic sel, logic [31:0] addr, hsize_e size, logic write);
    if (port == PORT_A) begin
      hsel_a   <= sel;
      haddr_a  <= addr;
      hsize_a  <= size;
      hwrite_a <= write;
    end else begin
      hsel_b   <= sel;
      haddr_b  <= addr;
      hsize_b  <= size;
      hwrite_b <= write;
    end
  endtask

  task automatic drive_sel(bit port, logic sel);
    if (port == PORT_A) hsel_a <= sel;
    else hsel_b <= sel;
  endtask

  task automatic drive_wdata(bit port, logic [DATA_W-1:0] data);
    if (port == PORT_A) hwdata_a <= data;
    else hwdata_b <= data;
  endtask

  function automatic logic port_ready(bit port);
    return (port == PORT_B) ? hready_b : hready_a;
  endfunction

  function automatic logic [DATA_W-1:0] port_rdata(bit port);
    return (port == PORT_B) ? hrdata_b : hrdata_a;
  endfunction

  // Called at a falling edge and returns at the falling edge with hready high
  task automatic poll_ready(bit port, string name, output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b1;
    while (!port_ready(port)) begin
      if (waited >= WAIT_LIMIT) begin
        $display("%s: hready on port %s stayed low past the wait limit", name,
                 (port == PORT_B) ? "B" : "A");
        wait_errors++;
        ok = 1'b0;
        return;
      end
      @(negedge hclk);
      waited++;
    end
  endtask

  task automatic finish_read(bit port, logic [31:0] addr, hsize_e size, bit stall, string name);
    bit ok;
    @(negedge hclk);
    push_ready({name, " first data cycle"}, !stall, port_ready(port));
    if (stall) begin
      @(negedge hclk);                                          // Exactly one low cycle
      push_ready({name, " after stall"}, 1'b1, port_ready(port));
    end
    poll_ready(port, name, ok);
    if (ok) begin
      push_data(name, ref_read(addr, size), port_rdata(port));
    end
  endtask

  task automatic single_read(bit port, logic [31:0] addr, hsize_e size, string name);
    bit ok;
    @(posedge hclk);
    drive_addr(port, 1'b1, addr, size, 1'b0);
    @(negedge hclk);
    poll_ready(port, name, ok);
    @(posedge hclk);                                            // Address phase taken
    drive_sel(port, 1'b0);
    if (ok) begin
      finish_read(port, addr, size, 1'b0, name);
    end
  endtask

  task automatic single_write(bit port, logic [31:0] addr, hsize_e size,
                              logic [DATA_W-1:0] data, string name);
    bit ok;
    @(posedge hclk);
    drive_addr(port, 1'b1, addr, size, 1'b1);
    @(negedge hclk);
    poll_ready(port, name, ok);
    @(posedge hclk);
    drive_sel(port, 1'b0);
    drive_wdata(port, data);                                    // Data phase
    ref_write(addr, size, data);
    @(negedge hclk);
    push_ready({name, " data phase"}, 1'b1, port_ready(port));
    @(posedge hclk);                                            // Lanes commit here
    @(negedge hclk);
    push_ready({name, " after commit"}, 1'b1, port_ready(port)); // No stall behind a write
  endtask

  // Read address phase sits in the write data phase
  task automatic write_then_read(bit port, logic [31:0] waddr, logic [31:0] raddr,
                                 hsize_e size, logic [DATA_W-1:0] data, string name);
    bit ok;
    @(posedge hclk);
    drive_addr(port, 1'b1, waddr, size, 1'b1);
    @(negedge hclk);
    poll_ready(port, name, ok);
    @(posedge hclk);
    drive_wdata(port, data);
    drive_addr(port, 1'b1, raddr, size, 1'b0);
    ref_write(waddr, size, data);
    @(negedge hclk);
    poll_ready(port, name, ok);
    @(posedge hclk);
    drive_sel(port, 1'b0);                                      // haddr held through stall
    finish_read(port, raddr, size, 1'b1, name);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0]       addrs [16];
    logic [31:0]       a_addr [8];
    logic [31:0]       b_addr [8];
    logic [DATA_W-1:0] a_data [8];
    logic [DATA_W-1:0] b_data [8];
    logic [DATA_W-1:0] line;
    logic [31:0]       addr;

    hresetn  = 1'b0;
    hsel_a   = 1'b0;
    haddr_a  = '0;
    hsize_a  = HSIZE_WORD;
    hwrite_a = 1'b0;
    hwdata_a = '0;
    hsel_b   = 1'b0;
    haddr_b  = '0;
    hsize_b  = HSIZE_WORD;
    hwrite_b = 1'b0;
    hwdata_b = '0;
    repeat (16) @(posedge hclk);
    hresetn <= 1'b1;

    @(negedge hclk);
    push_ready("reset hready_a", 1'b1, hready_a);
    push_ready("reset hready_b", 1'b1, hready_b);
    push_data("reset hrdata_a", '0, hrdata_a);
    push_data("reset hrdata_b", '0, hrdata_b);

    // Known contents everywhere before any word traffic
    for (int r = 0; r < LANE_DEPTH; r++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        line[i*LANE_W +: LANE_W] = fill_word(row_t'(r), i);
      end
      single_write(PORT_A, 32'(r) << 4, HSIZE_LINE, line, "fill line write");
    end

    for (int k = 0; k < 16; k++) begin
      addrs[k] = next_rand() & WORD_MASK;
      single_write(PORT_A, addrs[k], HSIZE_WORD, rand_line(), "port a word write");
    end
    for (int k = 0; k < 16; k++) begin
      single_read(PORT_A, addrs[k], HSIZE_WORD, "port a word read");
      single_read(PORT_A, addrs[k] & LINE_MASK, HSIZE_LINE, "port a row after word write");
    end

    for (int k = 0; k < 12; k++) begin
      addrs[k] = next_rand() & LINE_MASK;
      single_write(PORT_B, addrs[k], HSIZE_LINE, rand_line(), "port b line write");
    end
    for (int k = 0; k < 12; k++) begin
      single_read(PORT_B, addrs[k], HSIZE_LINE, "port b line read");
    end

    for (int k = 0; k < 8; k++) begin
      addr = next_rand() & WORD_MASK;
      single_write(PORT_A, addr, HSIZE_WORD, rand_line(), "cross write a");
      single_read(PORT_B, addr, HSIZE_WORD, "cross word read b");
      single_read(PORT_B, addr & LINE_MASK, HSIZE_LINE, "cross line read b");
      addr = next_rand() & LINE_MASK;
      single_write(PORT_B, addr, HSIZE_LINE, rand_line(), "cross write b");
      single_read(PORT_A, addr, HSIZE_LINE, "cross line read a");
      single_read(PORT_A, addr | 32'h8, HSIZE_WORD, "cross word read a");
    end

    for (int k = 0; k < 6; k++) begin
      addr = next_rand() & WORD_MASK;
      write_then_read(PORT_A, addr, addr, HSIZE_WORD, rand_line(), "stall same word a");
      write_then_read(PORT_A, addr, next_rand() & WORD_MASK, HSIZE_WORD, rand_line(),
                      "stall other word a");
      addr = next_rand() & LINE_MASK;
      write_then_read(PORT_B, addr, addr, HSIZE_LINE, rand_line(), "stall same line b");
      write_then_read(PORT_B, addr, next_rand() & LINE_MASK, HSIZE_LINE, rand_line(),
                      "stall other line b");
    end

    for (int k = 0; k < 8; k++) begin
      a_addr[k] = next_rand() & LINE_MASK & ~TOP_ROW;
      b_addr[k] = (next_rand() & WORD_MASK) | TOP_ROW;
      a_data[k] = rand_line();
      b_data[k] = rand_line();
    end
    fork
      begin
        for (int k = 0; k < 8; k++) begin
          single_write(PORT_A, a_addr[k], HSIZE_LINE, a_data[k], "parallel line write a");
          single_read(PORT_A, a_addr[k], HSIZE_LINE, "parallel line read a");
        end
      end
      begin
        for (int k = 0; k < 8; k++) begin
          single_write(PORT_B, b_addr[k], HSIZE_WORD, b_data[k], "parallel word write b");
          single_read(PORT_B, b_addr[k], HSIZE_WORD, "parallel word read b");
        end
      end
    join

    repeat (4) @(posedge hclk);                                 // Drain compare queues
    $display("Summary: %0d data errors, %0d hready errors, %0d wait timeouts",
             data_errors, ready_errors, wait_errors);
    if (data_errors + ready_errors + wait_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
common/sram_wrap_pkg.sv
sram_wrap/dp_sram_lane.sv
sram_wrap/ahb_port_ctrl.sv
sram_wrap/sram_wrap_dp.sv
bench/sram_wrap_checker.sv
bench/tb_sram_wrap.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_sram_wrap \
  -f src.f

# An assertion stop gives a non-zero exit, which is kept in the log
./obj_dir/Vtb_sram_wrap > sim.log 2>&1 || echo "Simulator exit status was not zero" >> sim.log

cat sim.log

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
